/* rtl/dnc_element_if.sv */
/*
  Indexed vector element bus
  One element per clock while enable is high, no handshake back
*/

`timescale 1ns/1ps

interface dnc_element_if;

  // Element strobe
  logic             enable;
  // Position of the element in the vector
  dnc_pkg::index_t  index;
  // Element value
  dnc_pkg::weight_t data;
  // Marks element N-1
  logic             last;

  modport source (
    output enable,
    output index,
    output data,
    output last
  );

  modport sink (
    input enable,
    input index,
    input data,
    input last
  );

endinterface

/* rtl/dnc_pkg.sv */
/*
  DNC precedence weighting package
  Word, index and length types and the sequencer phase encoding
*/

`include "dnc_settings.svh"

package dnc_pkg;

  // One weight or precedence value, unsigned fixed point
  typedef logic [`DNC_WEIGHT_BITS-1:0] weight_t;

  // Element position 0 to N-1
  typedef logic [$clog2(`DNC_MAX_N)-1:0] index_t;

  // Vector length 1 to N, one bit wider than an index
  typedef logic [$clog2(`DNC_MAX_N+1)-1:0] count_t;

  // Sequencer phases
  // idle      waits for start
  // collect_w takes the N write weights
  // collect_p takes the N previous precedence values
  typedef enum logic [1:0] {
    idle,
    collect_w,
    collect_p
  } phase_e;

endpackage

/* rtl/dnc_precedence_result.sv */
/*
  DNC precedence weighting, result stage
  Adds the write weight to the decayed precedence, clips at 1.0 and
  drives the output stream with the completion pulse
*/

`timescale 1ns/1ps
`include "dnc_settings.svh"

module dnc_precedence_result (
  input  logic             CLK,
  input  logic             RST,
  input  logic             term_enable,
  input  logic             term_last,
  input  dnc_pkg::weight_t decayed_p,
  input  dnc_pkg::weight_t w_term,
  output dnc_pkg::weight_t p_out,
  output logic             p_out_enable,
  output logic             ready
);

  localparam logic [`DNC_WEIGHT_BITS:0] sum_one = `DNC_ONE;
  localparam dnc_pkg::weight_t weight_one = `DNC_ONE;

  // One carry bit above the word
  logic [`DNC_WEIGHT_BITS:0] sum_full;
  dnc_pkg::weight_t          sum_sat;

  ////////////////////////////////////////////////////////////////////////////
  // Add and saturate
  ////////////////////////////////////////////////////////////////////////////

  assign sum_full = {1'b0, decayed_p} + {1'b0, w_term};
  // A weighting never exceeds 1.0
  assign sum_sat  = (sum_full > sum_one) ? weight_one : sum_full[`DNC_WEIGHT_BITS-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      p_out        <= '0;
      p_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      p_out_enable <= term_enable;
      // Completion rides with element N-1
      ready        <= term_last;
      if (term_enable) begin
        p_out <= sum_sat;
      end
    end
  end

endmodule

/* rtl/dnc_precedence_update.sv */
/*
  DNC precedence weighting, update stage
  Buffers the write weights by index and forms gate * p_old for each
  precedence element, paired with the matching weight
*/

`timescale 1ns/1ps
`include "dnc_settings.svh"

module dnc_precedence_update (
  input  logic             CLK,
  input  logic             RST,
  dnc_element_if.sink      w_bus,
  dnc_element_if.sink      p_bus,
  input  dnc_pkg::weight_t gate,
  output logic             term_enable,
  output logic             term_last,
  output dnc_pkg::weight_t decayed_p,
  output dnc_pkg::weight_t w_term
);

  localparam int prod_bits = 2 * `DNC_WEIGHT_BITS;

  // Write weights of the current request
  dnc_pkg::weight_t       w_buf [`DNC_MAX_N];
  // Full weight vector is in the buffer
  logic                   w_loaded;
  logic [prod_bits-1:0]   product;

  ////////////////////////////////////////////////////////////////////////////
  // Weight buffer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (w_bus.enable) begin
      w_buf[w_bus.index] <= w_bus.data;
    end
  end

  // Set by the last w, cleared by the last p
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_loaded <= 1'b0;
    end else if (w_bus.enable && w_bus.last) begin
      w_loaded <= 1'b1;
    end else if (p_bus.enable && p_bus.last) begin
      w_loaded <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decay multiply
  ////////////////////////////////////////////////////////////////////////////

  // Gate is at most 1.0, so the shifted product fits one word
  assign product = prod_bits'(gate) * prod_bits'(p_bus.data);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      term_enable <= 1'b0;
      term_last   <= 1'b0;
    end else begin
      // p before the weights are complete carries no valid term
      term_enable <= p_bus.enable && w_loaded;
      term_last   <= p_bus.enable && p_bus.last && w_loaded;
    end
  end

  // Truncating shift back to 15 fraction bits
  always_ff @(posedge CLK) begin
    decayed_p <= product[`DNC_FRAC_BITS +: `DNC_WEIGHT_BITS];
    w_term    <= w_buf[p_bus.index];
  end

endmodule

/* rtl/dnc_precedence_weighting.sv */
/*
  DNC precedence weighting, top level
  p_new(j) = (1 - sum w) * p_old(j) + w(j), streamed one element per strobe
  Sequencer, update and result stages joined by element buses
*/

`timescale 1ns/1ps

module dnc_precedence_weighting (
  input  logic             CLK,
  input  logic             RST,

  // Request control
  input  logic             start,
  output logic             ready,
  input  dnc_pkg::count_t  size_n_in,

  // Write weight stream
  input  logic             w_in_enable,
  input  dnc_pkg::weight_t w_in,

  // Previous precedence stream
  input  logic             p_in_enable,
  input  dnc_pkg::weight_t p_in,

  // New precedence stream
  output logic             p_out_enable,
  output dnc_pkg::weight_t p_out
);

  // Tagged element buses
  dnc_element_if w_bus ();
  dnc_element_if p_bus ();

  // Retention gate
  dnc_pkg::weight_t gate;

  // Update to result terms
  logic             term_enable;
  logic             term_last;
  dnc_pkg::weight_t decayed_p;
  dnc_pkg::weight_t w_term;

  ////////////////////////////////////////////////////////////////////////////
  // Stages
  ////////////////////////////////////////////////////////////////////////////

  dnc_weighting_sequencer u_sequencer (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size_n_in   (size_n_in),
    .w_in_enable (w_in_enable),
    .p_in_enable (p_in_enable),
    .w_in        (w_in),
    .p_in        (p_in),
    .w_bus       (w_bus.source),
    .p_bus       (p_bus.source),
    .gate        (gate)
  );

  dnc_precedence_update u_update (
    .CLK         (CLK),
    .RST         (RST),
    .w_bus       (w_bus.sink),
    .p_bus       (p_bus.sink),
    .gate        (gate),
    .term_enable (term_enable),
    .term_last   (term_last),
    .decayed_p   (decayed_p),
    .w_term      (w_term)
  );

  dnc_precedence_result u_result (
    .CLK          (CLK),
    .RST          (RST),
    .term_enable  (term_enable),
    .term_last    (term_last),
    .decayed_p    (decayed_p),
    .w_term       (w_term),
    .p_out        (p_out),
    .p_out_enable (p_out_enable),
    .ready        (ready)
  );

endmodule

/* rtl/dnc_settings.svh */
/*
  DNC precedence weighting, global settings
  Word format and vector length limits used by the RTL and the testbench
*/

`ifndef DNC_SETTINGS_SVH
`define DNC_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Number format
////////////////////////////////////////////////////////////////////////////

// Width of one weight or precedence word
`define DNC_WEIGHT_BITS 16
// Unsigned fixed point, all bits below the unit bit
`define DNC_FRAC_BITS 15
// Fixed-point 1.0
`define DNC_ONE 32768

// Largest vector length N
`define DNC_MAX_N 16

`endif

/* rtl/dnc_weighting_sequencer.sv */
/*
  DNC precedence weighting, request sequencer
  Decodes start and length, steps through the w and p streams,
  tags each element with index and last, and forms the retention
  gate 1.0 minus the saturated weight sum
*/

`timescale 1ns/1ps
`include "dnc_settings.svh"

module dnc_weighting_sequencer (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  dnc_pkg::count_t  size_n_in,
  input  logic             w_in_enable,
  input  logic             p_in_enable,
  input  dnc_pkg::weight_t w_in,
  input  dnc_pkg::weight_t p_in,
  dnc_element_if.source    w_bus,
  dnc_element_if.source    p_bus,
  output dnc_pkg::weight_t gate
);

  // Sum of up to N words needs log2(N) extra bits
  localparam int sum_bits = `DNC_WEIGHT_BITS + $clog2(`DNC_MAX_N);
  localparam logic [sum_bits-1:0] sum_one = `DNC_ONE;
  localparam dnc_pkg::weight_t weight_one = `DNC_ONE;

  dnc_pkg::phase_e     phase;
  dnc_pkg::count_t     size_n;
  dnc_pkg::index_t     elem_cnt;
  logic [sum_bits-1:0] w_sum;
  logic                gate_load;
  logic                elem_last;
  logic                w_accept;
  logic                p_accept;
  dnc_pkg::weight_t    w_sum_sat;

  // Capture stage, shared by both streams
  logic                cap_w_enable;
  logic                cap_p_enable;
  logic                cap_last;
  dnc_pkg::index_t     cap_index;
  dnc_pkg::weight_t    cap_data;

  ////////////////////////////////////////////////////////////////////////////
  // Element accept and position decode
  ////////////////////////////////////////////////////////////////////////////

  // Strobes outside their phase are dropped
  assign w_accept  = (phase == dnc_pkg::collect_w) && w_in_enable;
  assign p_accept  = (phase == dnc_pkg::collect_p) && p_in_enable;
  // Counter sits on element N-1
  assign elem_last = ((dnc_pkg::count_t'(elem_cnt) + 5'd1) == size_n);

  // Sum clipped at 1.0 so the gate never goes negative
  assign w_sum_sat = (w_sum > sum_one) ? weight_one : w_sum[`DNC_WEIGHT_BITS-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Phase FSM, counter, weight sum and gate
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase        <= dnc_pkg::idle;
      size_n       <= '0;
      elem_cnt     <= '0;
      w_sum        <= '0;
      gate_load    <= 1'b0;
      gate         <= '0;
      cap_w_enable <= 1'b0;
      cap_p_enable <= 1'b0;
    end else begin
      cap_w_enable <= w_accept;
      cap_p_enable <= p_accept;
      // Gate follows one edge after the last w lands in the sum
      gate_load    <= w_accept && elem_last;
      if (gate_load) begin
        gate <= weight_one - w_sum_sat;
      end
      case (phase)
        dnc_pkg::idle: begin
          if (start) begin
            size_n   <= size_n_in;
            elem_cnt <= '0;
            w_sum    <= '0;
            phase    <= dnc_pkg::collect_w;
          end
        end
        dnc_pkg::collect_w: begin
          if (w_in_enable) begin
            w_sum <= w_sum + sum_bits'(w_in);
            if (elem_last) begin
              // Counter rewinds for the p stream
              elem_cnt <= '0;
              phase    <= dnc_pkg::collect_p;
            end else begin
              elem_cnt <= elem_cnt + dnc_pkg::index_t'(1);
            end
          end
        end
        dnc_pkg::collect_p: begin
          if (p_in_enable) begin
            if (elem_last) begin
              elem_cnt <= '0;
              phase    <= dnc_pkg::idle;
            end else begin
              elem_cnt <= elem_cnt + dnc_pkg::index_t'(1);
            end
          end
        end
        default: phase <= dnc_pkg::idle;
      endcase
    end
  end

  // Element payload, tagged with its position
  always_ff @(posedge CLK) begin
    cap_index <= elem_cnt;
    cap_last  <= elem_last;
    cap_data  <= (phase == dnc_pkg::collect_p) ? p_in : w_in;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus drive, one cycle after the sampling edge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_bus.enable <= 1'b0;
      p_bus.enable <= 1'b0;
    end else begin
      w_bus.enable <= cap_w_enable;
      p_bus.enable <= cap_p_enable;
    end
  end

  // Both buses carry the same payload, only the strobe differs
  always_ff @(posedge CLK) begin
    w_bus.index <= cap_index;
    w_bus.data  <= cap_data;
    w_bus.last  <= cap_last;
    p_bus.index <= cap_index;
    p_bus.data  <= cap_data;
    p_bus.last  <= cap_last;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DNC precedence weighting testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

# Compile with assertions and timing support
verilator --binary --timing --assert -Wno-fatal \
  --top-module dnc_precedence_tb \
  -f tb.f \
  -o sim_dnc_precedence

# The log check below decides the verdict
./obj_dir/sim_dnc_precedence | tee "$LOG"

if grep -q "Simulation finished: PASS" "$LOG"; then
  echo "run_sim: test passed"
  exit 0
else
  echo "run_sim: test failed, see $LOG"
  exit 1
fi

/* tb.f */
+incdir+rtl
rtl/dnc_pkg.sv
rtl/dnc_element_if.sv
rtl/dnc_weighting_sequencer.sv
rtl/dnc_precedence_update.sv
rtl/dnc_precedence_result.sv
rtl/dnc_precedence_weighting.sv
verification/dnc_precedence_assertions.sv
verification/dnc_precedence_tb.sv

/* verification/dnc_precedence_assertions.sv */
/*
  DNC precedence weighting protocol and range checks
  Bound to the top level to watch the request strobes and the output range
*/

`timescale 1ns/1ps
`include "dnc_settings.svh"

module dnc_precedence_assertions (
  input logic             CLK,
  input logic             RST,
  input logic             start,
  input logic             w_in_enable,
  input logic             p_in_enable,
  input logic             ready,
  input logic             p_out_enable,
  input dnc_pkg::weight_t p_out,
  input dnc_pkg::phase_e  phase
);

  localparam dnc_pkg::weight_t weight_one = `DNC_ONE;

  ////////////////////////////////////////////////////////////////////////////
  // Completion pulse
  ////////////////////////////////////////////////////////////////////////////

  // One cycle wide
  ready_single: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ready stayed high for more than one cycle");

  // Rides with the last output element
  ready_with_out: assert property (@(posedge CLK) disable iff (RST) ready |-> p_out_enable)
    else $error("ready seen without p_out_enable");

  ////////////////////////////////////////////////////////////////////////////
  // Range and request phase
  ////////////////////////////////////////////////////////////////////////////

  // A weighting stays within 0 to 1.0
  p_out_range: assert property (@(posedge CLK) disable iff (RST) p_out <= weight_one)
    else $error("p_out above 1.0");

  w_strobe_phase: assert property (@(posedge CLK) disable iff (RST)
      w_in_enable |-> (phase == dnc_pkg::collect_w))
    else $error("w_in_enable outside the weight phase");

  p_strobe_phase: assert property (@(posedge CLK) disable iff (RST)
      p_in_enable |-> (phase == dnc_pkg::collect_p))
    else $error("p_in_enable outside the precedence phase");

  start_phase: assert property (@(posedge CLK) disable iff (RST)
      start |-> (phase == dnc_pkg::idle))
    else $error("start while a request is running");

endmodule

/* verification/dnc_precedence_tb.sv */
/*
  DNC precedence weighting testbench
  Directed requests against a fixed-point reference model
  Checks value, completion flag and latency of every output element
*/

`timescale 1ns/1ps
`include "dnc_settings.svh"

module dnc_precedence_tb;

  localparam dnc_pkg::weight_t weight_one = `DNC_ONE;
  // Output elements over all requests
  localparam int total_elems = 63;
  // 40 cycles per element plus margin
  localparam int cycle_limit = 40 * total_elems + 200;

  logic             CLK;
  logic             RST;
  logic             start;
  logic             ready;
  dnc_pkg::count_t  size_n_in;
  logic             w_in_enable;
  dnc_pkg::weight_t w_in;
  logic             p_in_enable;
  dnc_pkg::weight_t p_in;
  logic             p_out_enable;
  dnc_pkg::weight_t p_out;

  integer seed = 32'h7c33ce61;
  int cycle_cnt = 0;
  int mismatch_cnt = 0;
  int protocol_cnt = 0;
  int ready_cnt = 0;
  int requests_sent = 0;

  // Current request vectors
  dnc_pkg::weight_t w_vec [`DNC_MAX_N];
  dnc_pkg::weight_t p_vec [`DNC_MAX_N];
  dnc_pkg::weight_t exp_vec [`DNC_MAX_N];

  // Expected outputs in order with last flag and arrival cycle
  dnc_pkg::weight_t exp_val_q [$];
  logic             exp_last_q [$];
  int               exp_cycle_q [$];

  dnc_precedence_weighting uut (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .ready        (ready),
    .size_n_in    (size_n_in),
    .w_in_enable  (w_in_enable),
    .w_in         (w_in),
    .p_in_enable  (p_in_enable),
    .p_in         (p_in),
    .p_out_enable (p_out_enable),
    .p_out        (p_out)
  );

  bind dnc_precedence_weighting dnc_precedence_assertions u_assertions (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .w_in_enable  (w_in_enable),
    .p_in_enable  (p_in_enable),
    .ready        (ready),
    .p_out_enable (p_out_enable),
    .p_out        (p_out),
    .phase        (u_sequencer.phase)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) cycle_cnt <= cycle_cnt + 1;

  // Run limit
  initial begin
    wait (cycle_cnt >= cycle_limit);
    $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_weight(input dnc_pkg::weight_t actual,
                                input dnc_pkg::weight_t expected, input string what);
    if (actual !== expected) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic compare_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic compare_latency(input int actual, input int expected);
    if (actual != expected) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: output in cycle %0d, expected cycle %0d",
               $time, actual, expected);
    end
  endtask

  // Output monitor on the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (p_out_enable) begin
        if (exp_val_q.size() == 0) begin
          protocol_cnt++;
          $display("ERROR at %0t ns: output element with no request pending", $time);
        end else begin
          compare_weight(p_out, exp_val_q.pop_front(), "p_out");
          compare_flag(ready, exp_last_q.pop_front(), "ready");
          compare_latency(cycle_cnt, exp_cycle_q.pop_front());
        end
      end else if (ready) begin
        protocol_cnt++;
        $display("ERROR at %0t ns: ready pulsed without an output element", $time);
      end
      if (ready) begin
        ready_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and drivers
  ////////////////////////////////////////////////////////////////////////////

  // p_new = ((1 - sat(sum w)) * p_old >> 15) + w clipped at 1.0
  task automatic compute_expected(input int n);
    int unsigned sum;
    int unsigned gate_v;
    int unsigned total;
    sum = 0;
    for (int j = 0; j < n; j++) sum += w_vec[j];
    if (sum > weight_one) sum = weight_one;
    gate_v = weight_one - sum;
    for (int j = 0; j < n; j++) begin
      total = ((gate_v * p_vec[j]) >> `DNC_FRAC_BITS) + w_vec[j];
      exp_vec[j] = (total > weight_one) ? weight_one : dnc_pkg::weight_t'(total);
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic idle_cycles(input int max_gap);
    int gap;
    gap = (max_gap > 0) ? ($unsigned($random(seed)) % (max_gap + 1)) : 0;
    repeat (gap) next_cycle();
  endtask

  task automatic fill_random(input int n, input dnc_pkg::weight_t w_mask,
                             input dnc_pkg::weight_t p_mask, input dnc_pkg::weight_t p_set);
    for (int j = 0; j < n; j++) begin
      w_vec[j] = dnc_pkg::weight_t'($random(seed)) & w_mask;
      p_vec[j] = (dnc_pkg::weight_t'($random(seed)) & p_mask) | p_set;
    end
  endtask

  task automatic send_weights(input int n, input int max_gap);
    for (int j = 0; j < n; j++) begin
      idle_cycles(max_gap);
      w_in_enable = 1'b1;
      w_in        = w_vec[j];
      next_cycle();
      w_in_enable = 1'b0;
    end
  endtask

  task automatic send_precedence(input int n, input int max_gap);
    for (int j = 0; j < n; j++) begin
      idle_cycles(max_gap);
      p_in_enable = 1'b1;
      p_in        = p_vec[j];
      exp_val_q.push_back(exp_vec[j]);
      exp_last_q.push_back(j == n - 1);
      // Sampled on the next edge and out three cycles after it
      exp_cycle_q.push_back(cycle_cnt + 4);
      next_cycle();
      p_in_enable = 1'b0;
    end
  endtask

  task automatic run_request(input int n, input int max_gap);
    compute_expected(n);
    start     = 1'b1;
    size_n_in = dnc_pkg::count_t'(n);
    next_cycle();
    start = 1'b0;
    send_weights(n, max_gap);
    // Gate settles after the last weight
    repeat (2) next_cycle();
    send_precedence(n, max_gap);
    requests_sent++;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    while (ready_cnt < requests_sent && waited < 64) begin
      next_cycle();
      waited++;
    end
    if (ready_cnt < requests_sent) begin
      protocol_cnt++;
      $display("ERROR at %0t ns: ready never came for request %0d", $time, requests_sent);
    end
    // Catch stray outputs after completion
    repeat (4) next_cycle();
    if (exp_val_q.size() != 0) begin
      protocol_cnt++;
      $display("ERROR: %0d expected output elements never appeared", exp_val_q.size());
      exp_val_q.delete();
      exp_last_q.delete();
      exp_cycle_q.delete();
    end
    if (ready_cnt != requests_sent) begin
      protocol_cnt++;
      $display("ERROR: ready pulsed %0d times for %0d requests", ready_cnt, requests_sent);
      ready_cnt = requests_sent;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_and_first_step();
    compare_flag(ready, 1'b0, "ready after reset");
    compare_flag(p_out_enable, 1'b0, "p_out_enable after reset");
    compare_weight(p_out, '0, "p_out after reset");
    for (int j = 0; j < 4; j++) begin
      w_vec[j] = '0;
      p_vec[j] = '0;
    end
    // One-hot 0.5 into an all-zero history
    w_vec[2] = weight_one >> 1;
    run_request(4, 0);
    wait_done();
  endtask

  task automatic test_decay();
    fill_random(8, '0, 16'h7fff, '0);
    // Sum 0.25 gives gate 0.75
    for (int j = 0; j < 8; j++) w_vec[j] = 16'd1024;
    run_request(8, 0);
    wait_done();
  endtask

  task automatic test_sum_saturation();
    fill_random(4, '0, 16'h7fff, '0);
    for (int j = 0; j < 4; j++) w_vec[j] = 16'd12000;
    run_request(4, 1);
    wait_done();
  endtask

  task automatic test_output_saturation();
    // History above 1.0 overflows the decayed term
    fill_random(4, '0, 16'h3fff, 16'hc000);
    for (int j = 0; j < 4; j++) w_vec[j] = 16'd2048;
    run_request(4, 0);
    wait_done();
    // Single weight above 1.0
    fill_random(2, '0, 16'h7fff, '0);
    w_vec[0] = 16'd40000;
    w_vec[1] = 16'd100;
    run_request(2, 0);
    wait_done();
  endtask

  task automatic test_length_and_gaps();
    fill_random(1, 16'h07ff, 16'h7fff, '0);
    run_request(1, 3);
    wait_done();
    fill_random(16, 16'h07ff, 16'h7fff, '0);
    run_request(16, 3);
    wait_done();
  endtask

  task automatic test_back_to_back();
    fill_random(5, 16'h07ff, 16'h7fff, '0);
    run_request(5, 0);
    fill_random(16, 16'h07ff, 16'h7fff, '0);
    run_request(16, 0);
    fill_random(3, 16'h0fff, 16'h7fff, '0);
    run_request(3, 0);
    wait_done();
  endtask

  initial begin
    RST         = 1'b1;
    start       = 1'b0;
    size_n_in   = '0;
    w_in_enable = 1'b0;
    w_in        = '0;
    p_in_enable = 1'b0;
    p_in        = '0;
    repeat (5) @(posedge CLK);
    #1 RST = 1'b0;
    next_cycle();
    test_reset_and_first_step();
    test_decay();
    test_sum_saturation();
    test_output_saturation();
    test_length_and_gaps();
    test_back_to_back();
    $display("Error count: %0d value mismatches, %0d protocol errors",
             mismatch_cnt, protocol_cnt);
    if (mismatch_cnt + protocol_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
